//--- cpuSettings.svh
// Width settings for the decode stage and anything built around it
// Include wherever a data width, register count or index width is needed
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Register and datapath width
`define DATA_WIDTH 16

`define REG_COUNT  16   // Architectural registers, r0 reads as zero

// Register index width, log2 of REG_COUNT
`define REG_BITS   4

`endif

//--- decodePkg.sv
// Opcode and condition encodings plus the bundles passed to later stages
// Import in a module body, use scoped names in port lists
`include "cpuSettings.svh"

package decodePkg;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Top nibble of the instruction, encoded 0..15 in listed order
  typedef enum logic [3:0] {
    ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB,   // ALU group, doubles as ALU op
    LW, SW, LLB, LHB,                            // Memory and byte loads
    B, BR, PCS, HLT                              // Flow control
  } opcodeT;

  // Branch condition field, instruction bits [11:9]
  typedef enum logic [2:0] {
    NE, EQ, GT, LT, GTE, LTE, OVF, UNCOND
  } condT;

  typedef struct packed {
    logic zf;   // Zero
    logic vf;   // Overflow
    logic nf;   // Negative
  } flagsT;

  ////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////

  // Execute stage, 63 bits
  typedef struct packed {
    logic [`REG_BITS-1:0]   srcReg1;
    logic [`REG_BITS-1:0]   srcReg2;
    logic [`DATA_WIDTH-1:0] aluIn1;
    logic [`DATA_WIDTH-1:0] aluImm;
    logic [`DATA_WIDTH-1:0] aluIn2;
    opcodeT                 aluOp;
    logic                   aluSrc;   // Immediate in place of aluIn2
    logic                   zEn;
    logic                   nvEn;
  } exSignalsT;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] memWriteData;   // Store data for SW
    logic                   memEnable;
    logic                   memWrite;
  } memSignalsT;

  typedef struct packed {
    logic [`REG_BITS-1:0] regRd;
    logic                 regWrite;
    logic                 memToReg;   // Load result instead of ALU result
    logic                 hlt;
    logic                 pcs;
  } wbSignalsT;

  // Write-back port into the register file
  typedef struct packed {
    logic                   en;
    logic [`REG_BITS-1:0]   rd;
    logic [`DATA_WIDTH-1:0] data;
  } regWriteT;

  // Branch outcome and predictor update requests, 22 bits
  typedef struct packed {
    logic                   isBranch;
    logic                   isBr;
    logic                   actualTaken;
    logic                   wenBtb;
    logic                   wenBht;
    logic                   updatePc;   // Misprediction, redirect fetch
    logic [`DATA_WIDTH-1:0] target;
  } branchInfoT;

endpackage

//--- controlUnit.sv
// Opcode decoder for execute, memory and write-back control
// Also compares the resolved branch with the prediction for predictor updates
`timescale 1ns/100ps
`include "cpuSettings.svh"

module controlUnit (
  input  decodePkg::opcodeT      opcode,
  input  logic                   actualTaken,
  input  logic                   predictedTaken,
  input  logic [`DATA_WIDTH-1:0] predictedTarget,
  input  logic [`DATA_WIDTH-1:0] actualTarget,
  output decodePkg::opcodeT      aluOp,
  output logic                   aluSrc,
  output logic                   regSrc,      // rd as first source, LLB/LHB
  output logic                   zEn,
  output logic                   nvEn,
  output logic                   memEnable,
  output logic                   memWrite,
  output logic                   regWrite,
  output logic                   memToReg,
  output logic                   hlt,
  output logic                   pcs,
  output logic                   isBranch,
  output logic                   wenBtb,
  output logic                   wenBht,
  output logic                   updatePc
);
  import decodePkg::*;

  logic dirWrong;   // Direction mispredicted
  logic tgtWrong;   // Taken, but not where predicted

  ////////////////////////////////////////
  // Stage control
  ////////////////////////////////////////

  always_comb begin
    case (opcode)
      ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB, LLB, LHB: aluOp = opcode;
      default: aluOp = ADD;   // Address add for LW/SW, unused elsewhere
    endcase
  end

  assign aluSrc    = opcode inside {SLL, SRA, ROR, LW, SW, LLB, LHB};
  assign regSrc    = opcode inside {LLB, LHB};
  assign zEn       = opcode inside {ADD, SUB, XOR, SLL, SRA, ROR};
  assign nvEn      = opcode inside {ADD, SUB};   // Only arithmetic sets N and V
  assign memEnable = opcode inside {LW, SW};
  assign memWrite  = (opcode == SW);
  assign memToReg  = (opcode == LW);
  assign regWrite  = (opcode inside {ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB})
                   | (opcode inside {LW, LLB, LHB, PCS});
  assign hlt       = (opcode == HLT);
  assign pcs       = (opcode == PCS);

  ////////////////////////////////////////
  // Predictor decisions
  ////////////////////////////////////////

  assign isBranch = opcode inside {B, BR};
  assign dirWrong = (actualTaken != predictedTaken);
  assign tgtWrong = actualTaken && (actualTarget != predictedTarget);

  assign wenBht   = isBranch;                  // History trained on every branch
  assign wenBtb   = isBranch && actualTaken;   // Target kept only when taken
  assign updatePc = isBranch && (dirWrong || tgtWrong);

  // A store must also open the memory port in the next stage
  memWriteNeedsEnable: assert final (!memWrite || memEnable)
    else $error("controlUnit memWrite without memEnable, opcode %0d", opcode);

endmodule

//--- branchControl.sv
// Branch resolution for B and BR
// Tests the condition field against the flags and forms the branch target
`timescale 1ns/100ps
`include "cpuSettings.svh"

module branchControl (
  input  decodePkg::condT        cond,
  input  logic [8:0]             offset,   // Word offset, signed
  input  decodePkg::flagsT       flags,
  input  logic [`DATA_WIDTH-1:0] rsData,   // Register target for BR
  input  logic                   isBr,
  input  logic [`DATA_WIDTH-1:0] pcNext,
  output logic                   taken,
  output logic [`DATA_WIDTH-1:0] target
);
  import decodePkg::*;

  logic [`DATA_WIDTH-1:0] offsetExt;   // Sign extended, in bytes

  always_comb begin
    case (cond)
      NE:      taken = !flags.zf;
      EQ:      taken = flags.zf;
      GT:      taken = !flags.zf && !flags.nf;
      LT:      taken = flags.nf;
      GTE:     taken = flags.zf || !flags.nf;
      LTE:     taken = flags.nf || flags.zf;
      OVF:     taken = flags.vf;
      default: taken = 1'b1;   // UNCOND
    endcase
  end

  // Shift left one since instructions are halfword aligned
  assign offsetExt = {{(`DATA_WIDTH-10){offset[8]}}, offset, 1'b0};

  assign target = isBr ? rsData : (pcNext + offsetExt);

  // PC relative targets stay aligned
  pcRelAligned: assert final (isBr || !target[0])
    else $error("branchControl odd target %h from pcNext %h", target, pcNext);

endmodule

//--- regWriteDecoder.sv
// Write-back port decode into one enable per register cell
// r0 never gets an enable so it keeps its reset value of zero
`timescale 1ns/100ps
`include "cpuSettings.svh"

module regWriteDecoder (
  input  decodePkg::regWriteT    regWrite,
  output logic [`REG_COUNT-1:0]  writeEn,
  output logic [`DATA_WIDTH-1:0] writeData
);

  always_comb begin
    writeEn = '0;
    if (regWrite.en && (regWrite.rd != '0)) begin
      writeEn[regWrite.rd] = 1'b1;   // Single cell selected
    end
  end

  // Same data goes to every cell, the enable picks the target
  assign writeData = regWrite.data;

  // At most one cell loads per clock and r0 is never among them
  oneCellWrite: assert final ($onehot0(writeEn) && !writeEn[0])
    else $error("regWriteDecoder bad enables %h", writeEn);

endmodule

//--- regCell.sv
// One architectural register with write-through onto its read value
// Instantiated once per register by the register file
`timescale 1ns/100ps
`include "cpuSettings.svh"

module regCell (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   writeEn,
  input  logic [`DATA_WIDTH-1:0] writeData,
  output logic [`DATA_WIDTH-1:0] readData
);

  logic [`DATA_WIDTH-1:0] dataQ;   // Stored value

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataQ <= '0;
    end else if (writeEn) begin
      dataQ <= writeData;
    end
  end

  assign readData = writeEn ? writeData : dataQ;   // Bypass during the write cycle

  // Bypassed value is what the cell holds afterwards
  storeMatchesBypass: assert property (@(posedge clk) disable iff (!rstN)
    writeEn |=> (dataQ == $past(writeData)))
    else $error("regCell stored %h after write", dataQ);

endmodule

//--- regReadMux.sv
// Two independent read ports over all register cells
// Pure selection, each port indexed by its own source register
`timescale 1ns/100ps
`include "cpuSettings.svh"

module regReadMux (
  input  logic [`DATA_WIDTH-1:0] cellData [`REG_COUNT],
  input  logic [`REG_BITS-1:0]   srcReg1,
  input  logic [`REG_BITS-1:0]   srcReg2,
  output logic [`DATA_WIDTH-1:0] srcData1,
  output logic [`DATA_WIDTH-1:0] srcData2
);

  // Port 1, feeds aluIn1 and the BR target
  always_comb begin
    srcData1 = cellData[srcReg1];
  end

  // Port 2, feeds aluIn2 and store data
  always_comb begin
    srcData2 = cellData[srcReg2];
  end

endmodule

//--- registerFile.sv
// Sixteen-entry register file, one write port and two read ports
// Write decoder in front of the cells, read mux behind them
`timescale 1ns/100ps
`include "cpuSettings.svh"

module registerFile (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`REG_BITS-1:0]   srcReg1,
  input  logic [`REG_BITS-1:0]   srcReg2,
  input  decodePkg::regWriteT    regWrite,
  output logic [`DATA_WIDTH-1:0] srcData1,
  output logic [`DATA_WIDTH-1:0] srcData2
);

  logic [`REG_COUNT-1:0]  writeEn;                 // One-hot or zero
  logic [`DATA_WIDTH-1:0] writeData;               // Shared by all cells
  logic [`DATA_WIDTH-1:0] cellData [`REG_COUNT];   // Per cell read values

  regWriteDecoder regWriteDecoder_inst (
    .regWrite  (regWrite),
    .writeEn   (writeEn),
    .writeData (writeData)
  );

  for (genvar i = 0; i < `REG_COUNT; i++) begin : gCell
    regCell regCell_inst (
      .clk       (clk),
      .rstN      (rstN),
      .writeEn   (writeEn[i]),
      .writeData (writeData),
      .readData  (cellData[i])
    );
  end

  regReadMux regReadMux_inst (
    .cellData (cellData),
    .srcReg1  (srcReg1),
    .srcReg2  (srcReg2),
    .srcData1 (srcData1),
    .srcData2 (srcData2)
  );

endmodule

//--- decodeStage.sv
// Instruction decode stage top, combinational apart from the register file
// Feeds execute, memory and write-back bundles plus branch results to fetch
`timescale 1ns/100ps
`include "cpuSettings.svh"

module decodeStage (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`DATA_WIDTH-1:0] pcInst,
  input  logic [`DATA_WIDTH-1:0] pcNext,
  input  decodePkg::flagsT       flags,
  input  logic                   predictedTaken,
  input  logic [`DATA_WIDTH-1:0] predictedTarget,
  input  decodePkg::regWriteT    regWrite,   // From write-back
  output decodePkg::exSignalsT   exSignals,
  output decodePkg::memSignalsT  memSignals,
  output decodePkg::wbSignalsT   wbSignals,
  output decodePkg::branchInfoT  branchInfo
);
  import decodePkg::*;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  opcodeT                 opcode;
  condT                   cond;
  logic [`REG_BITS-1:0]   rd;
  logic [`REG_BITS-1:0]   rs;
  logic [`REG_BITS-1:0]   rt;
  logic [7:0]             imm8;       // LLB/LHB byte
  logic [3:0]             imm4;       // Shift amount or memory offset
  logic [8:0]             offset;     // Branch offset
  logic                   isBr;       // Register target, bit 12 of B/BR
  logic [`REG_BITS-1:0]   srcReg1;
  logic [`REG_BITS-1:0]   srcReg2;
  logic [`DATA_WIDTH-1:0] srcData1;
  logic [`DATA_WIDTH-1:0] srcData2;
  logic [`DATA_WIDTH-1:0] aluImm;

  // Control unit outputs
  opcodeT aluOp;
  logic   aluSrc;
  logic   regSrc;
  logic   zEn;
  logic   nvEn;
  logic   memEnable;
  logic   memWrite;
  logic   wbRegWrite;   // Not the incoming write-back port
  logic   memToReg;
  logic   hlt;
  logic   pcs;
  logic   isBranch;
  logic   wenBtb;
  logic   wenBht;
  logic   updatePc;

  // Branch resolution
  logic                   actualTaken;
  logic [`DATA_WIDTH-1:0] target;

  assign opcode = opcodeT'(pcInst[15:12]);
  assign cond   = condT'(pcInst[11:9]);
  assign rd     = pcInst[11:8];
  assign rs     = pcInst[7:4];
  assign rt     = pcInst[3:0];
  assign imm8   = pcInst[7:0];
  assign imm4   = pcInst[3:0];
  assign offset = pcInst[8:0];
  assign isBr   = pcInst[12];

  // LLB/LHB read rd to merge the byte, SW reads rd as store data
  assign srcReg1 = regSrc ? rd : rs;
  assign srcReg2 = memWrite ? rd : rt;

  always_comb begin
    if (regSrc) begin
      aluImm = {{(`DATA_WIDTH-8){1'b0}}, imm8};
    end else if (memEnable) begin
      aluImm = {{(`DATA_WIDTH-4){imm4[3]}}, imm4};   // Signed memory offset
    end else begin
      aluImm = {{(`DATA_WIDTH-4){1'b0}}, imm4};
    end
  end

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  controlUnit controlUnit_inst (
    .opcode          (opcode),
    .actualTaken     (actualTaken),
    .predictedTaken  (predictedTaken),
    .predictedTarget (predictedTarget),
    .actualTarget    (target),
    .aluOp           (aluOp),
    .aluSrc          (aluSrc),
    .regSrc          (regSrc),
    .zEn             (zEn),
    .nvEn            (nvEn),
    .memEnable       (memEnable),
    .memWrite        (memWrite),
    .regWrite        (wbRegWrite),
    .memToReg        (memToReg),
    .hlt             (hlt),
    .pcs             (pcs),
    .isBranch        (isBranch),
    .wenBtb          (wenBtb),
    .wenBht          (wenBht),
    .updatePc        (updatePc)
  );

  branchControl branchControl_inst (
    .cond   (cond),
    .offset (offset),
    .flags  (flags),
    .rsData (srcData1),
    .isBr   (isBr),
    .pcNext (pcNext),
    .taken  (actualTaken),
    .target (target)
  );

  registerFile registerFile_inst (
    .clk      (clk),
    .rstN     (rstN),
    .srcReg1  (srcReg1),
    .srcReg2  (srcReg2),
    .regWrite (regWrite),
    .srcData1 (srcData1),
    .srcData2 (srcData2)
  );

  ////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////

  always_comb begin
    exSignals.srcReg1 = srcReg1;
    exSignals.srcReg2 = srcReg2;
    exSignals.aluIn1  = srcData1;
    exSignals.aluImm  = aluImm;
    exSignals.aluIn2  = srcData2;   // Execute picks this or aluImm on aluSrc
    exSignals.aluOp   = aluOp;
    exSignals.aluSrc  = aluSrc;
    exSignals.zEn     = zEn;
    exSignals.nvEn    = nvEn;

    memSignals.memWriteData = srcData2;
    memSignals.memEnable    = memEnable;
    memSignals.memWrite     = memWrite;

    wbSignals.regRd    = rd;
    wbSignals.regWrite = wbRegWrite;
    wbSignals.memToReg = memToReg;
    wbSignals.hlt      = hlt;
    wbSignals.pcs      = pcs;

    branchInfo.isBranch    = isBranch;
    branchInfo.isBr        = isBr;
    branchInfo.actualTaken = actualTaken;
    branchInfo.wenBtb      = wenBtb;
    branchInfo.wenBht      = wenBht;
    branchInfo.updatePc    = updatePc;
    branchInfo.target      = target;
  end

endmodule

//--- decodeStage_tb.sv
// Table-driven testbench for the decode stage top level
// Builds rows with a shadow register model, then drives each row and compares every bundle
`timescale 1ns/100ps
`include "cpuSettings.svh"

module decodeStage_tb;
  import decodePkg::*;

  localparam int clkPeriod   = 4;
  localparam int resetCycles = 3;
  localparam bit hi = 1'b1;
  localparam bit lo = 1'b0;

  // Expected control for one opcode
  typedef struct packed {
    opcodeT aluOp;
    logic   aluSrc;
    logic   zEn;
    logic   nvEn;
    logic   memEnable;
    logic   memWrite;
    logic   regWrite;
    logic   memToReg;
    logic   hlt;
    logic   pcs;
    logic   isBranch;
  } ctrlT;

  // One table row with stimulus followed by the expected bundles
  typedef struct packed {
    regWriteT               wr;
    logic [`DATA_WIDTH-1:0] inst;
    logic [`DATA_WIDTH-1:0] pcNext;
    flagsT                  flags;
    logic                   predTaken;
    logic [`DATA_WIDTH-1:0] predTarget;
    exSignalsT              expEx;
    memSignalsT             expMem;
    wbSignalsT              expWb;
    branchInfoT             expBr;
  } rowT;

  logic                   clk;
  logic                   rstN;
  logic [`DATA_WIDTH-1:0] pcInst;
  logic [`DATA_WIDTH-1:0] pcNext;
  flagsT                  flags;
  logic                   predictedTaken;
  logic [`DATA_WIDTH-1:0] predictedTarget;
  regWriteT               regWrite;
  exSignalsT              exSignals;
  memSignalsT             memSignals;
  wbSignalsT              wbSignals;
  branchInfoT             branchInfo;

  logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];   // Register contents as the table sees them
  logic [15:0]            lfsrState = 16'd17;
  ctrlT                   ctrlTable [16];        // Indexed by opcode
  rowT                    rows [$];
  int                     numRows = 0;

  // Taken mask per condition indexed by {zf, vf, nf}
  logic [7:0] takenMask [8] = '{
    8'h0F,   // NE  Z clear
    8'hF0,   // EQ  Z set
    8'h05,   // GT  Z and N clear
    8'hAA,   // LT  N set
    8'hF5,   // GTE Z set or N clear
    8'hFA,   // LTE N set or Z set
    8'hCC,   // OVF V set
    8'hFF    // UNCOND
  };

  decodeStage decodeStage_inst (
    .clk             (clk),
    .rstN            (rstN),
    .pcInst          (pcInst),
    .pcNext          (pcNext),
    .flags           (flags),
    .predictedTaken  (predictedTaken),
    .predictedTarget (predictedTarget),
    .regWrite        (regWrite),
    .exSignals       (exSignals),
    .memSignals      (memSignals),
    .wbSignals       (wbSignals),
    .branchInfo      (branchInfo)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
      val = {val[14:0], lfsrState[0]};
    end
    return val;
  endfunction

  function automatic regWriteT randomWrite();
    regWriteT    w;
    logic [15:0] b;
    b = randBits(1);
    w.en = b[0];
    b = randBits(4);
    w.rd = b[3:0];
    w.data = randBits(16);
    return w;
  endfunction

  function automatic logic [15:0] randomPc();
    logic [15:0] b;
    b = randBits(15);
    return {b[14:0], 1'b0};   // Halfword aligned
  endfunction

  // Read value seen during the write cycle with r0 fixed at zero
  function automatic logic [15:0] regValue(input logic [3:0] idx, input regWriteT wr);
    if (idx == 4'd0) return 16'h0000;
    if (wr.en && (wr.rd == idx)) return wr.data;   // Write-through
    return shadow[idx];
  endfunction

  task automatic fillControlTable();
    //                 aluOp   src zEn nvEn mEn mWr rWr m2r hlt pcs br
    ctrlTable[ADD]    = '{ADD,    lo, hi, hi, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[SUB]    = '{SUB,    lo, hi, hi, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[XOR]    = '{XOR,    lo, hi, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[RED]    = '{RED,    lo, lo, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[SLL]    = '{SLL,    hi, hi, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[SRA]    = '{SRA,    hi, hi, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[ROR]    = '{ROR,    hi, hi, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[PADDSB] = '{PADDSB, lo, lo, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[LW]     = '{ADD,    hi, lo, lo, hi, lo, hi, hi, lo, lo, lo};   // Address add
    ctrlTable[SW]     = '{ADD,    hi, lo, lo, hi, hi, lo, lo, lo, lo, lo};
    ctrlTable[LLB]    = '{LLB,    hi, lo, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[LHB]    = '{LHB,    hi, lo, lo, lo, lo, hi, lo, lo, lo, lo};
    ctrlTable[B]      = '{ADD,    lo, lo, lo, lo, lo, lo, lo, lo, lo, hi};
    ctrlTable[BR]     = '{ADD,    lo, lo, lo, lo, lo, lo, lo, lo, lo, hi};
    ctrlTable[PCS]    = '{ADD,    lo, lo, lo, lo, lo, hi, lo, lo, hi, lo};
    ctrlTable[HLT]    = '{ADD,    lo, lo, lo, lo, lo, lo, lo, hi, lo, lo};
  endtask

  // Mode 0 predicts right, mode 1 flips the direction and mode 2 moves the target
  task automatic addRow(input regWriteT wr, input logic [15:0] inst, input flagsT fl,
                        input logic [15:0] pcNextIn, input int mode);
    rowT         r;
    ctrlT        c;
    opcodeT      op;
    logic [3:0]  src1;
    logic [3:0]  src2;
    logic [15:0] d1;
    logic [15:0] d2;
    logic [15:0] imm;
    logic [15:0] tgt;
    logic        taken;
    op   = opcodeT'(inst[15:12]);
    c    = ctrlTable[op];
    src1 = (op == LLB || op == LHB) ? inst[11:8] : inst[7:4];
    src2 = (op == SW) ? inst[11:8] : inst[3:0];
    d1   = regValue(src1, wr);
    d2   = regValue(src2, wr);
    if (op == LLB || op == LHB) imm = {8'h00, inst[7:0]};
    else if (op == LW || op == SW) imm = {{12{inst[3]}}, inst[3:0]};
    else imm = {12'h000, inst[3:0]};
    taken = takenMask[inst[11:9]][{fl.zf, fl.vf, fl.nf}];
    tgt   = inst[12] ? d1 : (pcNextIn + {{6{inst[8]}}, inst[8:0], 1'b0});
    r.wr = wr;
    r.inst = inst;
    r.pcNext = pcNextIn;
    r.flags = fl;
    case (mode)
      0: begin
        r.predTaken  = taken;
        r.predTarget = tgt;
      end
      1: begin
        r.predTaken  = !taken;
        r.predTarget = tgt;
      end
      default: begin
        r.predTaken  = taken;
        r.predTarget = tgt ^ 16'h0010;
      end
    endcase
    r.expEx = '{src1, src2, d1, imm, d2, c.aluOp, c.aluSrc, c.zEn, c.nvEn};
    r.expMem = '{d2, c.memEnable, c.memWrite};
    r.expWb = '{inst[11:8], c.regWrite, c.memToReg, c.hlt, c.pcs};
    r.expBr.isBranch    = c.isBranch;
    r.expBr.isBr        = inst[12];
    r.expBr.actualTaken = taken;
    r.expBr.wenBtb      = c.isBranch && taken;
    r.expBr.wenBht      = c.isBranch;
    r.expBr.updatePc    = c.isBranch && ((taken != r.predTaken) ||
                                         (taken && (tgt != r.predTarget)));
    r.expBr.target      = tgt;
    rows.push_back(r);
    if (wr.en && (wr.rd != 4'd0)) shadow[wr.rd] = wr.data;   // Lands at the next edge
  endtask

  task automatic buildTable();
    regWriteT    wr;
    logic [15:0] bits;
    logic [15:0] flagBits;
    logic [3:0]  r;
    opcodeT      op;
    for (int k = 0; k < 16; k++) shadow[k] = 16'h0000;   // Reset state
    // Fill r1 to r15 while port 1 reads the register being written
    for (int k = 1; k < 16; k++) begin
      r = k[3:0];
      wr.en = 1'b1;
      wr.rd = r;
      wr.data = randBits(16);
      addRow(wr, {ADD, r, r, r - 4'd1}, '0, 16'h0000, 0);
    end
    wr.rd = 4'd0;                                        // Write to r0 is dropped
    wr.data = randBits(16);
    addRow(wr, {ADD, 12'h000}, '0, 16'h0000, 0);
    wr.en = 1'b0;
    for (int k = 0; k < 16; k++) begin                   // Read back on both ports
      r = k[3:0];
      addRow(wr, {XOR, r, r, ~r}, '0, 16'h0000, 0);
    end
    // Every opcode twice with random fields
    for (int p = 0; p < 2; p++) begin
      for (int o = 0; o < 16; o++) begin
        wr = randomWrite();
        bits = randBits(12);
        flagBits = randBits(3);
        r = o[3:0];
        addRow(wr, {r, bits[11:0]}, flagsT'(flagBits[2:0]), randomPc(), (o + p) % 3);
      end
    end
    // All conditions against all flag values
    for (int cc = 0; cc < 8; cc++) begin
      for (int f = 0; f < 8; f++) begin
        wr = randomWrite();
        bits = randBits(9);
        op = ((cc + f) % 2 == 1) ? BR : B;
        addRow(wr, {op, cc[2:0], bits[8:0]}, flagsT'(f[2:0]), randomPc(), (cc * 8 + f) % 3);
      end
    end
    numRows = rows.size();
  endtask

  task automatic driveRow(input rowT r);
    pcInst          = r.inst;
    pcNext          = r.pcNext;
    flags           = r.flags;
    predictedTaken  = r.predTaken;
    predictedTarget = r.predTarget;
    regWrite        = r.wr;
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic failRun();
    $display(">>> FAIL");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic checkEx(input int row, input exSignalsT got, input exSignalsT exp);
    if (got !== exp) begin
      $display("error exSignals row %0d got %h expected %h", row, got, exp);
      failRun();
    end
  endtask

  task automatic checkMem(input int row, input memSignalsT got, input memSignalsT exp);
    if (got !== exp) begin
      $display("error memSignals row %0d got %h expected %h", row, got, exp);
      failRun();
    end
  endtask

  task automatic checkWb(input int row, input wbSignalsT got, input wbSignalsT exp);
    if (got !== exp) begin
      $display("error wbSignals row %0d got %h expected %h", row, got, exp);
      failRun();
    end
  endtask

  task automatic checkBranch(input int row, input branchInfoT got, input branchInfoT exp);
    if (got !== exp) begin
      $display("error branchInfo row %0d got %h expected %h", row, got, exp);
      failRun();
    end
  endtask

  ////////////////////////////////////////
  // Run
  ////////////////////////////////////////

  initial begin : mainSeq
    rstN            = 1'b0;
    pcInst          = '0;
    pcNext          = '0;
    flags           = '0;
    predictedTaken  = 1'b0;
    predictedTarget = '0;
    regWrite        = '0;
    fillControlTable();
    buildTable();
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);                         // Release on a falling edge
    rstN = 1'b1;
    for (int i = 0; i < numRows; i++) begin
      driveRow(rows[i]);                    // Falling edge
      #(clkPeriod / 2.0 - 0.5);             // Just before the rising edge
      checkEx(i, exSignals, rows[i].expEx);
      checkMem(i, memSignals, rows[i].expMem);
      checkWb(i, wbSignals, rows[i].expWb);
      checkBranch(i, branchInfo, rows[i].expBr);
      @(negedge clk);
    end
    $display(">>> PASS");
    $finish;
  end

  // Twice the table length plus reset
  initial begin : watchdog
    wait (numRows > 0);
    #(numRows * clkPeriod * 2 + resetCycles * clkPeriod);
    $display("Timed out with %0d table rows not finished at %0t", numRows, $time);
    failRun();
  end

endmodule

//--- project.f
+incdir+.
decodePkg.sv
controlUnit.sv
branchControl.sv
regWriteDecoder.sv
regCell.sv
regReadMux.sv
registerFile.sv
decodeStage.sv
decodeStage_tb.sv
